/* uopFrontEnd.f */
design/uopPkg.sv
design/instrFetch.sv
design/microOpSequencer.sv
design/decodeStage.sv
design/uopFrontEnd.sv
bench/uopFrontEndTb.sv

/* Makefile */
# Verilator build and run of the micro-op decode front end testbench

SIM ?= verilator
TOP ?= uopFrontEndTb
VFLAGS ?= --binary --timing --assert -j 0
BUILD ?= obj_dir
FILELIST ?= uopFrontEnd.f

SRCS := $(wildcard design/*.sv) $(wildcard bench/*.sv)
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD)

/* bench/uopInput.txt */
# I <word>: instruction memory, one word per line from resetPc upward
# E <instr> <ra1> <ra2> <wa3> <flags>: expected bundle, flags = ra1FromRz noFlagUpdate prevRsr keepV
I E0821003
I E0865817
I E0214392
I E0A32594
I E3A04005
I E0010392
I E0510352
I E037A998
I E0F76899
I E04A900B
E E0821003 02 03 01 0
E E1A0F817 10 07 0F C
E E086500F 16 0F 05 2
E E00F0392 0F 02 00 1
E E08F1004 0F 04 11 6
E E08FE594 1F 04 1E 1
E E092200E 02 1E 02 3
E E0A3300F 03 1F 03 2
E E3A04005 00 05 04 0
E E0010392 01 02 00 0
E E1A0F352 10 02 0F C
E E051000F 11 0F 00 2
E E00F0998 0F 08 00 1
E E09F700A 0F 0A 17 6
E E0CFE899 1F 09 1E 1
E E096600E 06 1E 06 3
E E0B7700F 07 1F 07 2
E E04A900B 0A 0B 09 0

/* bench/uopFrontEndTb.sv */
// testbench for the decode front end, replays bench/uopInput.txt under random stall and ack delay
module uopFrontEndTb;

	logic clk;
	logic reset;
	uopPkg::wbReq wb;
	logic [31:0] wbDat;
	logic wbAck;
	logic stall;
	uopPkg::uopBundle uop;
	logic uopValid;

	logic [31:0] imem[$];	// instruction words by word address
	uopPkg::uopBundle expQ[$];	// expected bundles in issue order
	int seenCount;	// bundles taken by execute so far
	int cycles;
	int limit;
	logic [29:0] nextAdr;	// address the next request must carry
	logic reqActive;
	logic ackPending;	// ack is on the bus, taken at the coming edge
	int waitLeft;	// cycles until this request gets its ack

	uopFrontEnd dut_i (
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.wbDat(wbDat),
		.wbAck(wbAck),
		.stall(stall),
		.uop(uop),
		.uopValid(uopValid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic uopPkg::wbReq makeReq(input logic active, input logic [29:0] adr);
		uopPkg::wbReq r;
		r.cyc = active;
		r.stb = active;
		r.adr = adr;
		return r;
	endfunction

	// words past the program get a pattern built from the full address
	function automatic logic [31:0] readWord(input logic [29:0] adr);
		if ({2'b00, adr} < imem.size()) begin
			return imem[adr];
		end
		return {2'b10, adr};
	endfunction

	task automatic stopRun();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic checkBundle(input string name, input uopPkg::uopBundle got,
		input uopPkg::uopBundle exp);
		if (got !== exp) begin
			$display("[ERROR] %s #%0d: got %h expected %h (instr %h, expected %h)",
				name, seenCount, got, exp, got.instr, exp.instr);
			stopRun();
		end
	endtask

	task automatic checkBus(input string name, input uopPkg::wbReq got, input uopPkg::wbReq exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic loadStimulus();
		int fd;
		int n;
		string line;
		string rest;
		logic [31:0] w;
		logic [4:0] a1;
		logic [4:0] a2;
		logic [4:0] a3;
		logic [3:0] fl;
		uopPkg::uopBundle b;
		fd = $fopen("bench/uopInput.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file bench/uopInput.txt");
			stopRun();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;	// blank or comment line
			end
			rest = line.substr(1, line.len() - 1);
			if (line.getc(0) == "I") begin
				n = $sscanf(rest, "%h", w);
				if (n != 1) begin
					$display("malformed instruction line in the stimulus file");
					stopRun();
				end
				imem.push_back(w);
			end else if (line.getc(0) == "E") begin
				n = $sscanf(rest, "%h %h %h %h %h", w, a1, a2, a3, fl);
				if (n != 5) begin
					$display("malformed expected-bundle line in the stimulus file");
					stopRun();
				end
				b.instr = w;
				b.ra1 = a1;
				b.ra2 = a2;
				b.wa3 = a3;
				{b.ra1FromRz, b.noFlagUpdate, b.prevRsr, b.keepV} = fl;
				expQ.push_back(b);
			end else begin
				$display("unknown line kind in the stimulus file");
				stopRun();
			end
		end
		$fclose(fd);
	endtask

	// wishbone slave, one request at a time with a 0 to 3 cycle wait
	task automatic serveBus();
		if (ackPending) begin
			wbAck = 1'b0;
			ackPending = 1'b0;
			reqActive = 1'b0;
			checkBus("wb", wb, makeReq(1'b0, nextAdr));	// idle cycle, pc already moved on
		end else if (wb.cyc || wb.stb || reqActive) begin
			if (!reqActive) begin
				reqActive = 1'b1;
				waitLeft = $urandom % 4;
			end
			checkBus("wb", wb, makeReq(1'b1, nextAdr));	// held and stable until ack
			if (waitLeft == 0) begin
				wbAck = 1'b1;
				wbDat = readWord(nextAdr);
				ackPending = 1'b1;
				nextAdr = nextAdr + 30'd1;
			end else begin
				waitLeft--;
			end
		end
	endtask

	// a bundle moves on the next edge when valid and not stalled
	always @(negedge clk) begin
		if (!reset && uopValid && !stall && seenCount < expQ.size()) begin
			checkBundle("uop", uop, expQ[seenCount]);
			seenCount++;
		end
	end

	initial begin
		void'($urandom(32'h91f));	// single seed for ack delay and stall
		reset = 1'b1;
		stall = 1'b0;
		wbAck = 1'b0;
		wbDat = '0;
		seenCount = 0;
		cycles = 0;
		nextAdr = uopPkg::resetPc;
		reqActive = 1'b0;
		ackPending = 1'b0;
		waitLeft = 0;
		loadStimulus();
		limit = expQ.size() * 12 + 100;	// generous per-bundle budget plus startup
		repeat (8) @(posedge clk);
		#10;
		checkBus("wb", wb, makeReq(1'b0, uopPkg::resetPc));	// bus quiet out of reset
		checkFlag("uopValid", uopValid, 1'b0);
		reset = 1'b0;
		while (seenCount < expQ.size() && cycles < limit) begin
			@(posedge clk);
			#10;
			cycles++;
			serveBus();
			stall = ($urandom % 10) < 3;	// about 30 percent back-pressure
		end
		if (seenCount == expQ.size()) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("timeout: micro-op stream stalled");
			stopRun();
		end
	end

endmodule

/* design/uopFrontEnd.sv */
// top of the decode front end, wishbone fetch in and registered micro-op bundles out
module uopFrontEnd (
	input logic clk,
	input logic reset,
	output uopPkg::wbReq wb,
	input logic [31:0] wbDat,
	input logic wbAck,
	input logic stall,
	output uopPkg::uopBundle uop,
	output logic uopValid
);

	logic [31:0] instr;
	logic instrValid;
	logic advance;	// current word fully used
	logic hold;
	uopPkg::seqCtrl ctrl;
	logic [31:0] uopWord;

	instrFetch fetch_i (
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.wbDat(wbDat),
		.wbAck(wbAck),
		.advance(advance),
		.instr(instr),
		.instrValid(instrValid)
	);

	microOpSequencer seq_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.hold(hold),
		.ctrl(ctrl),
		.uopWord(uopWord)
	);

	decodeStage decode_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.ctrl(ctrl),
		.uopWord(uopWord),
		.stall(stall),
		.hold(hold),
		.advance(advance),
		.uop(uop),
		.uopValid(uopValid)
	);

endmodule

/* design/decodeStage.sv */
// decode stage, picks the issued word, extends register addresses and registers the bundle
module decodeStage (
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	input logic instrValid,
	input uopPkg::seqCtrl ctrl,
	input logic [31:0] uopWord,
	input logic stall,
	output logic hold,
	output logic advance,
	output uopPkg::uopBundle uop,
	output logic uopValid
);

	logic [31:0] word;	// word issued this cycle
	uopPkg::uopBundle nextUop;

	assign word = ctrl.instrMux ? uopWord : instr;

	// sequencer steps only when a bundle is actually taken
	assign hold = stall || !instrValid;
	// fetch may drop the word after the last micro-op
	assign advance = instrValid && !stall && !ctrl.uopStall;

	always_comb begin
		nextUop.instr = word;
		nextUop.ra1 = {ctrl.rz.ra1Hi, word[19:16]};	// Rn field
		nextUop.ra2 = {ctrl.rz.ra2Hi, word[3:0]};	// Rm field
		nextUop.wa3 = {ctrl.rz.wa3Hi, word[15:12]};	// Rd field
		nextUop.ra1FromRz = ctrl.rz.ra1FromRz;
		nextUop.noFlagUpdate = ctrl.noFlagUpdate;
		nextUop.prevRsr = ctrl.prevRsr;
		nextUop.keepV = ctrl.keepV;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			uopValid <= 1'b0;
		end else if (!stall) begin
			uopValid <= instrValid;	// bubble when fetch is empty
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && instrValid) begin
			uop <= nextUop;	// held while stall is high
		end
	end

	// execute sees the same bundle until it releases stall
	assert property (@(posedge clk) disable iff (reset)
		(uopValid && stall) |=> (uopValid && $stable(uop)))
		else $error("bundle changed under stall");

endmodule

/* design/microOpSequencer.sv */
// micro-op sequencer, splits rsr and multiply-accumulate words into short micro-op runs
module microOpSequencer (
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	input logic instrValid,
	input logic hold,
	output uopPkg::seqCtrl ctrl,
	output logic [31:0] uopWord
);

	uopPkg::seqState state;
	uopPkg::seqState nextState;
	logic isRsr;
	logic isMulAcc;

	// rsr data processing: bits 27:25 zero, bit 7 low, bit 4 high
	assign isRsr = instrValid && (instr[27:25] == 3'b000) && !instr[7] && instr[4];
	// multiply class with the accumulate bit set
	assign isMulAcc = instrValid && (instr[27:24] == 4'b0000) && instr[21]
		&& (instr[7:4] == 4'b1001);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::ready;
		end else if (!hold) begin
			state <= nextState;	// frozen under stall or empty fetch
		end
	end

	// mealy, every output gets a value before the case
	always_comb begin
		nextState = uopPkg::ready;
		ctrl = '0;
		uopWord = instr;	// pass-through unless overridden
		case (state)
			uopPkg::ready: begin
				if (isRsr) begin
					// mov Rz, Rm shifted by Rs, flags untouched
					nextState = uopPkg::rsr;
					ctrl.instrMux = 1'b1;
					ctrl.uopStall = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.rz.ra1FromRz = 1'b1;
					ctrl.rz.ra1Hi = 1'b1;
					uopWord = {instr[31:25], uopPkg::opMov, 1'b0,	// cond, mov, no S
						4'b0000, uopPkg::rzIndex,	// Rn sbz, Rd is Rz
						instr[11:0]};	// original Rs, shift type, Rm
				end else if (isMulAcc && !instr[23]) begin
					// mul Rz, Rm, Rs
					nextState = uopPkg::multiply;
					ctrl.instrMux = 1'b1;
					ctrl.uopStall = 1'b1;
					ctrl.keepV = 1'b1;
					uopWord = {instr[31:22], 2'b00,	// accumulate and S cleared
						uopPkg::rzIndex, 4'b0000,	// Rd is Rz, Rn sbz
						instr[11:0]};
				end else if (isMulAcc) begin
					// long multiply into the Rz pair, r31 high and r30 low
					nextState = uopPkg::multiply;
					ctrl.instrMux = 1'b1;
					ctrl.uopStall = 1'b1;
					ctrl.keepV = 1'b1;
					ctrl.rz.wa3Hi = 1'b1;
					ctrl.rz.ra1Hi = 1'b1;
					uopWord = {instr[31:22], 2'b00,	// keeps the U bit
						uopPkg::rzIndex,	// RdHi
						uopPkg::rzIndex - 4'd1,	// RdLo
						instr[11:0]};
				end
			end
			uopPkg::rsr: begin
				// original op, shifter operand replaced by plain Rz
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.rz.ra1Hi = 1'b1;
				uopWord = {instr[31:12], 8'h00, uopPkg::rzIndex};
			end
			uopPkg::multiply: begin
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				if (!instr[23]) begin
					// add Rd, Rz, Ra, S from the original
					ctrl.noFlagUpdate = 1'b1;
					ctrl.rz.wa3Hi = 1'b1;
					uopWord = {instr[31:28], 3'b000, uopPkg::opAdd, instr[20],
						uopPkg::rzIndex,	// Rn
						instr[19:16],	// Rd of mla
						8'h00, instr[15:12]};	// Ra as Rm
				end else begin
					// add RdLo, RdLo, r30; carry out feeds the adc
					nextState = uopPkg::multiply2;
					ctrl.uopStall = 1'b1;
					ctrl.keepV = 1'b1;
					ctrl.rz.ra2Hi = 1'b1;
					uopWord = {instr[31:28], 3'b000, uopPkg::opAdd, 1'b1,
						instr[15:12], instr[15:12],
						8'h00, uopPkg::rzIndex - 4'd1};
				end
			end
			uopPkg::multiply2: begin
				// adc RdHi, RdHi, r31
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.rz.ra2Hi = 1'b1;
				uopWord = {instr[31:28], 3'b000, uopPkg::opAdc, instr[20],
					instr[19:16], instr[19:16],
					8'h00, uopPkg::rzIndex};
			end
			default: nextState = uopPkg::ready;
		endcase
	end

	// at most three non-held steps from ready back to ready
	assert property (@(posedge clk) disable iff (reset)
		(state != uopPkg::ready && !hold) |=> (state == uopPkg::ready
			|| (state == uopPkg::multiply2 && $past(state) == uopPkg::multiply)))
		else $error("micro-op sequence did not return to ready");

	// a word is only held back while its micro-ops are being issued
	assert property (@(posedge clk) disable iff (reset)
		ctrl.uopStall |-> ctrl.instrMux)
		else $error("uopStall without micro-op select");

endmodule

/* design/instrFetch.sv */
// instruction fetch, one wishbone classic read at a time into a single instruction register
module instrFetch (
	input logic clk,
	input logic reset,
	output uopPkg::wbReq wb,
	input logic [31:0] wbDat,
	input logic wbAck,
	input logic advance,
	output logic [31:0] instr,
	output logic instrValid
);

	typedef enum logic {
		fetchIdle,
		fetchBusy
	} fetchState;

	fetchState state;
	logic [29:0] pc;	// word address of the next read
	logic startReq;
	logic ackTaken;

	assign startReq = !instrValid || advance;	// register is free by the next edge
	assign ackTaken = (state == fetchBusy) && wbAck;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetchIdle;
			pc <= uopPkg::resetPc;
		end else begin
			case (state)
				fetchIdle: begin
					if (startReq) begin
						state <= fetchBusy;	// cyc and stb rise together
					end
				end
				fetchBusy: begin
					if (wbAck) begin
						state <= fetchIdle;	// drop for at least one cycle
						pc <= pc + 30'd1;
					end
				end
				default: state <= fetchIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			instrValid <= 1'b0;
		end else if (ackTaken) begin
			instrValid <= 1'b1;	// register is empty while a read runs
		end else if (advance) begin
			instrValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ackTaken) begin
			instr <= wbDat;	// held until advance
		end
	end

	always_comb begin
		wb.cyc = (state == fetchBusy);
		wb.stb = (state == fetchBusy);
		wb.adr = pc;	// pc only moves on ack
	end

	// classic cycle: request and address stay put until the slave acks
	assert property (@(posedge clk) disable iff (reset)
		(wb.stb && !wbAck) |=> (wb.stb && $stable(wb.adr)))
		else $error("wishbone request changed before ack");

endmodule

/* design/uopPkg.sv */
// shared types and constants of the micro-op decode front end, used by scoped name
package uopPkg;

	localparam logic [3:0] rzIndex = 4'd15;	// low bits of Rz, r31 once the hi bit is set
	localparam logic [29:0] resetPc = 30'h0000_0000;	// word address of the first fetch

	// sequencer states
	typedef enum logic [1:0] {
		ready,	// no sequence running
		rsr,	// second half of a register-shifted-register op
		multiply,	// accumulate step of mla or long mla
		multiply2	// high-half step of long mla
	} seqState;

	// data-processing opcodes emitted by the sequencer, bits 24:21
	typedef enum logic [3:0] {
		opAdd = 4'b0100,
		opAdc = 4'b0101,
		opMov = 4'b1101
	} dpOpcode;

	typedef struct packed {
		logic ra1FromRz;	// read address 1 mux control
		logic wa3Hi;	// fifth bit of the write address
		logic ra2Hi;
		logic ra1Hi;
	} rzCtrl;

	typedef struct packed {
		logic instrMux;	// take the micro-op word
		logic uopStall;	// keep the current instruction in fetch
		logic noFlagUpdate;
		logic prevRsr;
		logic keepV;	// multiplier leaves V alone
		rzCtrl rz;
	} seqCtrl;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic [29:0] adr;	// word address
	} wbReq;

	// one registered micro-op for the execute stage
	typedef struct packed {
		logic [31:0] instr;
		logic [4:0] ra1;
		logic [4:0] ra2;
		logic [4:0] wa3;
		logic ra1FromRz;
		logic noFlagUpdate;
		logic prevRsr;
		logic keepV;
	} uopBundle;

endpackage
